/* rtl/bus_pkg.sv */
// ================================================
// Bus types shared by the SPI decoder, the executor
// and the memory target. One byte-wide bus, one
// master, no error or wait-state signalling.
// ================================================
package bus_pkg;

    localparam int BUS_ADDR_W    = 17;              // 128 KiB address space
    localparam int BUS_DATA_W    = 8;               // Byte-wide data
    localparam int BUS_MEM_DEPTH = 2 ** BUS_ADDR_W; // Words behind the memory target

    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [BUS_DATA_W-1:0] bus_data_t;

    // Request handed from the SCK domain to the clk_i domain
    // Only sampled by the executor once the valid bit has been synchronized
    typedef struct packed {
        logic      we;      // 1 = write, 0 = read
        bus_addr_t addr;    // Target address
        bus_data_t wdata;   // Write data, don't care on reads
    } bus_req_t;

endpackage

/* rtl/spi_cmd_pkg.sv */
// ================================================
// SPI command byte layout and decoder encoding.
// Argument order after the command byte is fixed:
// write data, address high, address low.
// ================================================
package spi_cmd_pkg;

    import bus_pkg::*;

    // First byte of every transaction
    typedef struct packed {
        logic       write;      // Bit 7, 1 = write cycle
        logic       set_addr;   // Bit 6, 1 = address bytes follow, 0 = increment
        logic [4:0] reserved;   // Ignored
        logic       a16;        // Bit 0, address bit 16 when set_addr is high
    } spi_cmd_t;

    // A received byte is either the command or a raw argument byte
    typedef union packed {
        spi_cmd_t  cmd;         // Decoded in DEC_CMD
        bus_data_t data;        // Data and address argument bytes
    } spi_rx_u;

    // Top bit flags a complete command, the clk_i side only watches that bit
    typedef enum logic [2:0] {
        DEC_CMD     = 3'b000,   // Waiting for command byte
        DEC_DATA    = 3'b001,   // Waiting for write data
        DEC_ADDR_HI = 3'b010,   // Waiting for address bits 15:8
        DEC_ADDR_LO = 3'b011,   // Waiting for address bits 7:0
        DEC_VALID   = 3'b100    // Command complete, request stable
    } dec_state_e;

endpackage

/* rtl/spi_shifter.sv */
// ================================================
// Mode 0 SPI slave shifter, MSB first, on SCK.
// SCK must idle low while chip select is high.
// byte_done_o and rx_byte_o are combinational and
// only meaningful at the eighth rising edge.
// ================================================
`timescale 1ns/1ps

module spi_shifter import bus_pkg::*, spi_cmd_pkg::*; (
    input  logic      arst_n_i,
    input  logic      spi_cs_n_i,   // Active low select
    input  logic      spi_sck_i,    // Serial clock, idle low
    input  logic      spi_sd_i,     // MCU to bridge
    input  bus_data_t tx_byte_i,    // Next byte to send
    output logic      spi_sd_o,     // Bridge to MCU
    output spi_rx_u   rx_byte_o,    // Completed byte
    output logic      byte_done_o   // High across the eighth bit
);

    logic       cnt_rst_n;      // Bit position restarts while deselected
    logic [2:0] bit_cnt;        // Rising edges seen in the current byte
    logic [6:0] rx_sr;          // First seven bits of the byte
    logic [7:0] tx_sr;          // Transmit shift register
    logic       first_q;        // No falling edge yet in this transaction

    assign cnt_rst_n = arst_n_i & ~spi_cs_n_i;

    always_ff @(posedge spi_sck_i or negedge cnt_rst_n) begin
        if (!cnt_rst_n) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 3'd1;  // Wraps every byte
        end
    end

    always_ff @(posedge spi_sck_i) begin
        rx_sr <= {rx_sr[5:0], spi_sd_i};    // Sample on rising edge
    end

    // Last bit comes straight from the pin so the decoder sees the full byte
    assign rx_byte_o.data = {rx_sr, spi_sd_i};
    assign byte_done_o    = (bit_cnt == 3'd7);

    // Output changes on falling edges only
    always_ff @(negedge spi_sck_i or negedge cnt_rst_n) begin
        if (!cnt_rst_n) begin
            first_q <= 1'b1;
            tx_sr   <= '0;
        end else begin
            first_q <= 1'b0;
            if (bit_cnt == 3'd0) begin
                tx_sr <= tx_byte_i;                 // Byte boundary, reload
            end else if (first_q) begin
                tx_sr <= {tx_byte_i[6:0], 1'b0};    // MSB already driven from tx_byte_i
            end else begin
                tx_sr <= {tx_sr[6:0], 1'b0};
            end
        end
    end

    assign spi_sd_o = first_q ? tx_byte_i[7] : tx_sr[7];   // MSB valid before first rise

endmodule

/* rtl/sync2_edge_detect.sv */
// ================================================
// Two-flop synchronizer into clk_i with edge pulses.
// Input must stay stable for 2+ clk_i cycles.
// Resets high, so a low input after reset gives a
// single fall pulse and no rise pulse.
// ================================================
`timescale 1ns/1ps

module sync2_edge_detect (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic data_i,    // Asynchronous level
    output logic rise_o,    // One clk_i pulse on 0 -> 1
    output logic fall_o     // One clk_i pulse on 1 -> 0
);

    logic meta_q;   // First stage, may go metastable
    logic sync_q;   // Safe to use
    logic prev_q;   // Last cycle's synchronized level

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            meta_q <= 1'b1;
            sync_q <= 1'b1;
            prev_q <= 1'b1;
        end else begin
            meta_q <= data_i;
            sync_q <= meta_q;
            prev_q <= sync_q;
        end
    end

    assign rise_o = sync_q & ~prev_q;
    assign fall_o = ~sync_q & prev_q;

endmodule

/* rtl/spi_cmd_decode.sv */
// ================================================
// Command decoder in the SCK domain.
// One command per chip select, extra bytes after
// DEC_VALID are ignored. The request stays stable
// until chip select rises.
// ================================================
`timescale 1ns/1ps

module spi_cmd_decode import bus_pkg::*, spi_cmd_pkg::*; (
    input  logic     arst_n_i,
    input  logic     spi_cs_n_i,    // Active low select
    input  logic     spi_sck_i,     // Serial clock
    input  spi_rx_u  rx_byte_i,     // Byte from the shifter
    input  logic     byte_done_i,   // Byte complete at this rising edge
    output bus_req_t req_o,         // Assembled bus request
    output logic     cmd_valid_o    // Request complete
);

    dec_state_e state_q;
    dec_state_e state_d;
    bus_req_t   req_q;
    logic       set_addr_q;     // Current command carries address bytes
    logic       dec_rst_n;
    spi_cmd_t   cmd;

    // Held in DEC_CMD while deselected, so each select starts clean
    assign dec_rst_n = arst_n_i & ~spi_cs_n_i;
    assign cmd       = rx_byte_i.cmd;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            DEC_CMD: begin
                if (cmd.write) begin
                    state_d = DEC_DATA;
                end else if (cmd.set_addr) begin
                    state_d = DEC_ADDR_HI;
                end else begin
                    state_d = DEC_VALID;    // Read at incremented address
                end
            end
            DEC_DATA:    state_d = set_addr_q ? DEC_ADDR_HI : DEC_VALID;
            DEC_ADDR_HI: state_d = DEC_ADDR_LO;
            DEC_ADDR_LO: state_d = DEC_VALID;
            default:     state_d = DEC_VALID;   // Sit here until deselect
        endcase
    end

    always_ff @(posedge spi_sck_i or negedge dec_rst_n) begin
        if (!dec_rst_n) begin
            state_q <= DEC_CMD;
        end else if (byte_done_i) begin
            state_q <= state_d;     // One step per byte
        end
    end

    // Address survives between transactions for increment mode
    always_ff @(posedge spi_sck_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q      <= '0;
            set_addr_q <= 1'b0;
        end else if (byte_done_i) begin
            unique case (state_q)
                DEC_CMD: begin
                    req_q.we   <= cmd.write;
                    set_addr_q <= cmd.set_addr;
                    if (cmd.set_addr) begin
                        req_q.addr[16] <= cmd.a16;  // Low bits follow as arguments
                    end else begin
                        req_q.addr <= req_q.addr + 1'b1;
                    end
                end
                DEC_DATA:    req_q.wdata      <= rx_byte_i.data;
                DEC_ADDR_HI: req_q.addr[15:8] <= rx_byte_i.data;
                DEC_ADDR_LO: req_q.addr[7:0]  <= rx_byte_i.data;
                default: ;                  // Request frozen once valid
            endcase
        end
    end

    assign req_o       = req_q;
    assign cmd_valid_o = state_q[2];    // Valid bit of the encoding

endmodule

/* rtl/bus_cycle_exec.sv */
// ================================================
// Executor in the clk_i domain. Runs one bus cycle
// per command and holds the last read byte for the
// next SPI transaction. req_i must be stable from
// cmd_go_i until the cycle ends.
// ================================================
`timescale 1ns/1ps

module bus_cycle_exec import bus_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      cs_sel_i,     // Chip select fell
    input  logic      cs_desel_i,   // Chip select rose
    input  logic      cmd_go_i,     // Command became valid
    input  bus_req_t  req_i,        // From the SCK domain, quasi static
    input  logic      ack_i,
    input  bus_data_t rdata_i,
    output logic      cyc_o,
    output logic      we_o,
    output bus_addr_t addr_o,
    output bus_data_t wdata_o,
    output bus_data_t tx_byte_o,    // Next byte shifted out to the MCU
    output logic      stall_o       // MCU must wait while high
);

    // Bit 1 requests the bus, bit 0 stalls the MCU
    typedef enum logic [1:0] {
        EXEC_READY      = 2'b00,
        EXEC_RECEIVING  = 2'b01,
        EXEC_PROCESSING = 2'b11
    } exec_state_e;

    exec_state_e state_q;
    bus_data_t   tx_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= EXEC_READY;
        end else if (cs_desel_i) begin
            state_q <= EXEC_READY;      // Deselect always wins
        end else begin
            unique case (state_q)
                EXEC_READY:      if (cs_sel_i) state_q <= EXEC_RECEIVING;
                EXEC_RECEIVING:  if (cmd_go_i) state_q <= EXEC_PROCESSING;
                EXEC_PROCESSING: if (ack_i)    state_q <= EXEC_READY;
                default:         state_q <= EXEC_READY;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tx_q <= '0;
        end else if (cyc_o && ack_i && !req_i.we) begin
            tx_q <= rdata_i;    // Writes leave the last read byte in place
        end
    end

    assign cyc_o     = state_q[1];
    assign stall_o   = state_q[0];
    assign we_o      = cyc_o & req_i.we;
    assign addr_o    = req_i.addr;
    assign wdata_o   = req_i.wdata;
    assign tx_byte_o = tx_q;

endmodule

/* rtl/bus_ram.sv */
// ================================================
// 128K x 8 memory target, single port.
// Access happens on the first cycle of cyc_i and
// ack_o follows one cycle later. Contents are not
// initialized.
// ================================================
`timescale 1ns/1ps

module bus_ram import bus_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      cyc_i,    // Held until ack_o
    input  logic      we_i,
    input  bus_addr_t addr_i,
    input  bus_data_t wdata_i,
    output logic      ack_o,    // One cycle pulse per request
    output bus_data_t rdata_o   // Valid with ack_o
);

    bus_data_t mem [BUS_MEM_DEPTH];
    logic      ack_q;
    logic      access;

    assign access = cyc_i & ~ack_q;     // First cycle only

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;    // Drops with cyc_i, never repeats
        end
    end

    always_ff @(posedge clk_i) begin
        if (access) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end
            rdata_o <= mem[addr_i];     // Old data on a write, unused
        end
    end

    assign ack_o = ack_q;

endmodule

/* rtl/spi_bridge_top.sv */
// ================================================
// SPI to memory bridge. MCU waits for spi_stall_o
// low before select and again before deselect.
// Read data comes back as the first byte of the
// following transaction.
// ================================================
`timescale 1ns/1ps

module spi_bridge_top import bus_pkg::*, spi_cmd_pkg::*; (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic spi_cs_n_i,
    input  logic spi_sck_i,
    input  logic spi_sd_i,
    output logic spi_sd_o,
    output logic spi_stall_o
);

    spi_rx_u   rx_byte;
    logic      byte_done;
    bus_data_t tx_byte;
    bus_req_t  req;
    logic      cmd_valid;
    logic      cs_sel;      // Select pulse in clk_i domain
    logic      cs_desel;    // Deselect pulse
    logic      cmd_go;      // Valid rising edge
    logic      cyc;
    logic      we;
    logic      ack;
    bus_addr_t addr;
    bus_data_t wdata;
    bus_data_t rdata;

    spi_shifter spi_shifter_inst (
        .arst_n_i, .spi_cs_n_i, .spi_sck_i, .spi_sd_i,
        .tx_byte_i(tx_byte), .spi_sd_o, .rx_byte_o(rx_byte), .byte_done_o(byte_done)
    );

    spi_cmd_decode spi_cmd_decode_inst (
        .arst_n_i, .spi_cs_n_i, .spi_sck_i, .rx_byte_i(rx_byte),
        .byte_done_i(byte_done), .req_o(req), .cmd_valid_o(cmd_valid)
    );

    // Chip select is active low, so its fall is the select
    sync2_edge_detect sync_cs (
        .clk_i, .arst_n_i, .data_i(spi_cs_n_i), .rise_o(cs_desel), .fall_o(cs_sel)
    );

    sync2_edge_detect sync_valid (
        .clk_i, .arst_n_i, .data_i(cmd_valid), .rise_o(cmd_go), .fall_o()
    );

    bus_cycle_exec bus_cycle_exec_inst (
        .clk_i, .arst_n_i, .cs_sel_i(cs_sel), .cs_desel_i(cs_desel), .cmd_go_i(cmd_go),
        .req_i(req), .ack_i(ack), .rdata_i(rdata), .cyc_o(cyc), .we_o(we), .addr_o(addr),
        .wdata_o(wdata), .tx_byte_o(tx_byte), .stall_o(spi_stall_o)
    );

    bus_ram bus_ram_inst (
        .clk_i, .arst_n_i, .cyc_i(cyc), .we_i(we), .addr_i(addr),
        .wdata_i(wdata), .ack_o(ack), .rdata_o(rdata)
    );

endmodule

/* verif/spi_bridge_tb.sv */
// ================================================
// Testbench for the SPI memory bridge. SCK runs at
// clk_i / 8, mode 0. Only the first byte returned
// per transaction is checked. Reads only target
// cells written earlier, the RAM has no init.
// ================================================
`timescale 1ns/1ps

module spi_bridge_tb import bus_pkg::*, spi_cmd_pkg::*; ();

    localparam int     CLK_HALF_NS   = 50;      // 100 ns clk_i period
    localparam int     SCK_HALF_CYC  = 4;       // clk_i cycles per SCK half period
    localparam int     NUM_ROWS      = 17;
    localparam int     TXN_WORST_CYC = 4 * 8 * 2 * SCK_HALF_CYC + 64;  // 4 bytes, stall, idle
    localparam longint WATCHDOG_NS   = 64'd2 * NUM_ROWS * TXN_WORST_CYC * 2 * CLK_HALF_NS
                                       + 64'd20 * CLK_HALF_NS;

    typedef struct packed {
        logic      write;       // 1 = write command
        logic      set_addr;    // 1 = address bytes sent, 0 = increment
        bus_addr_t addr;        // Ignored in increment mode
        bus_data_t data;        // Write data, filled from $random
    } stim_row_t;

    logic clk_i;
    logic arst_n_i;
    logic spi_cs_n_i;
    logic spi_sck_i;
    logic spi_sd_i;
    logic spi_sd_o;
    logic spi_stall_o;

    // Operation, set-address flag, address, data
    stim_row_t table_rows [NUM_ROWS] = '{
        {1'b1, 1'b1, 17'h00123, 8'h00},     // First transaction returns reset byte
        {1'b0, 1'b1, 17'h00123, 8'h00},
        {1'b1, 1'b1, 17'h01000, 8'h00},     // Increment run starts here
        {1'b1, 1'b0, 17'h00000, 8'h00},
        {1'b1, 1'b0, 17'h00000, 8'h00},
        {1'b1, 1'b0, 17'h00000, 8'h00},
        {1'b0, 1'b1, 17'h01000, 8'h00},
        {1'b0, 1'b0, 17'h00000, 8'h00},
        {1'b0, 1'b0, 17'h00000, 8'h00},
        {1'b0, 1'b0, 17'h00000, 8'h00},
        {1'b1, 1'b1, 17'h04567, 8'h00},     // Bank 0
        {1'b1, 1'b1, 17'h14567, 8'h00},     // Same low bits, bank 1
        {1'b0, 1'b1, 17'h04567, 8'h00},
        {1'b0, 1'b1, 17'h14567, 8'h00},
        {1'b1, 1'b1, 17'h00200, 8'h00},     // Write must not disturb the tx byte
        {1'b0, 1'b1, 17'h00200, 8'h00},
        {1'b1, 1'b1, 17'h00300, 8'h00}      // Flushes the last read result
    };

    bus_data_t ref_mem [bus_addr_t];    // Reference memory, written cells only
    bus_addr_t model_addr;              // Follows the decoder's address register
    bus_data_t model_tx;                // Last read byte, returned next transaction
    bus_data_t send_q [$];              // Bytes of the current transaction
    bus_data_t first_rx;
    logic      stall_seen;
    integer    seed;
    int        errors;
    int        checks;

    spi_bridge_top spi_bridge_top_inst (
        .clk_i, .arst_n_i, .spi_cs_n_i, .spi_sck_i, .spi_sd_i, .spi_sd_o, .spi_stall_o
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_HALF_NS) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the transactions did not complete within %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    task automatic compare_data(input string name, input bus_data_t exp, input bus_data_t act);
        checks++;
        if (act !== exp) begin
            $display("FAIL time %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_stall(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("FAIL time %0t %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    // Called on a clk_i edge with SCK low
    task automatic shift_byte(input bus_data_t tx, output bus_data_t rx);
        for (int i = 7; i >= 0; i--) begin
            spi_sd_i  <= tx[i];         // Change while SCK falls
            spi_sck_i <= 1'b0;
            repeat (SCK_HALF_CYC) @(posedge clk_i);
            rx[i]      = spi_sd_o;      // Stable since the last falling edge
            stall_seen = stall_seen | spi_stall_o;
            spi_sck_i <= 1'b1;
            repeat (SCK_HALF_CYC) @(posedge clk_i);
        end
    endtask

    task automatic run_transaction();
        bus_data_t rx;
        @(posedge clk_i);
        while (spi_stall_o) @(posedge clk_i);  // No select while busy
        spi_cs_n_i <= 1'b0;
        stall_seen  = 1'b0;
        foreach (send_q[k]) begin
            shift_byte(send_q[k], rx);
            if (k == 0) begin
                first_rx = rx;
            end
        end
        spi_sck_i <= 1'b0;              // Back to idle level
        @(posedge clk_i);
        stall_seen = stall_seen | spi_stall_o;
        while (spi_stall_o) @(posedge clk_i);  // Bus cycle done
        spi_cs_n_i <= 1'b1;
        repeat (8) @(posedge clk_i);    // Deselect passes the synchronizer
    endtask

    initial begin
        seed       = 32'hc708;
        errors     = 0;
        checks     = 0;
        model_addr = '0;
        model_tx   = '0;
        arst_n_i   = 1'b0;
        spi_cs_n_i = 1'b1;
        spi_sck_i  = 1'b0;
        spi_sd_i   = 1'b0;
        foreach (table_rows[r]) begin
            if (table_rows[r].write) begin
                table_rows[r].data = $random(seed);
            end
        end
        // Banks must hold different bytes to tell them apart
        if (table_rows[11].data == table_rows[10].data) begin
            table_rows[11].data = ~table_rows[10].data;
        end

        repeat (3) @(posedge clk_i);
        arst_n_i <= 1'b1;
        repeat (2) @(posedge clk_i);
        compare_stall("spi_stall_o after reset", 1'b0, spi_stall_o);
        $display("Reset: %s", (errors == 0) ? "ok" : "failed");

        for (int r = 0; r < NUM_ROWS; r++) begin : row_loop
            int        err_before;
            stim_row_t row;
            spi_cmd_t  cmd;
            err_before   = errors;
            row          = table_rows[r];
            model_addr   = row.set_addr ? row.addr : model_addr + 1'b1;
            cmd          = '0;
            cmd.write    = row.write;
            cmd.set_addr = row.set_addr;
            cmd.a16      = row.set_addr & row.addr[16];  // Bank bit only with an address
            send_q.delete();
            send_q.push_back(bus_data_t'(cmd));
            if (row.write) begin
                send_q.push_back(row.data);
            end
            if (row.set_addr) begin
                send_q.push_back(row.addr[15:8]);
                send_q.push_back(row.addr[7:0]);
            end
            run_transaction();
            compare_data("spi_sd_o first byte", model_tx, first_rx);
            compare_stall("spi_stall_o during transaction", 1'b1, stall_seen);
            if (row.write) begin
                ref_mem[model_addr] = row.data;
            end else if (ref_mem.exists(model_addr)) begin
                model_tx = ref_mem[model_addr];     // Expected in the next transaction
            end else begin
                $display("Row %0d reads address %h, which was never written", r, model_addr);
                errors++;
            end
            $display("Row %0d %s addr %h data %h: %s", r, row.write ? "write" : "read ",
                     model_addr, row.write ? row.data : model_tx,
                     (errors == err_before) ? "ok" : "failed");
        end

        $display("Done: %0d rows, %0d checks, %0d errors", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
rtl/bus_pkg.sv
rtl/spi_cmd_pkg.sv
rtl/spi_shifter.sv
rtl/sync2_edge_detect.sv
rtl/spi_cmd_decode.sv
rtl/bus_cycle_exec.sv
rtl/bus_ram.sv
rtl/spi_bridge_top.sv
verif/spi_bridge_tb.sv
